// File: sources.f
+incdir+verilog
verilog/cnn_pkg.sv
verilog/cnn_ctrl.sv
verilog/cnn_rd_chan.sv
verilog/cnn_mac.sv
verilog/cnn_wr_pack.sv
verilog/cnn_top.sv
tb/cnn_checker.sv
tb/tb_cnn.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= tb_cnn
RTL_TOP   ?= cnn_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
LINTFLAGS ?= -Wall
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: build
	-./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb/tb_cnn.sv
// Convolution engine testbench: clock, reset, byte memory with random latencies, test sequence
`timescale 1ns/1ns
`include "cnn_cfg.svh"

module tb_cnn;

  localparam int MEM_BYTES  = 1024;
  localparam int A_BIAS     = 'h000;
  localparam int A_KERN     = 'h010;
  localparam int A_PIC      = 'h100;
  localparam int A_RES      = 'h200;
  localparam int WAIT_LIMIT = 20000;      // Cycles allowed for any wait

  logic                   clk, rst_n, go, busy, done;
  logic [`CNN_ADDR_W-1:0] addr_bias, addr_x, addr_y, addr_z;
  logic [`CNN_DIM_W-1:0]  x_m, x_n;
  logic                   pic_req, pic_valid, wgt_req, wgt_valid, wr_req, wr_ack;
  logic [`CNN_ADDR_W-1:0] pic_addr, wgt_addr, wr_addr;
  logic [`CNN_SIZE_W-1:0] pic_size, wgt_size, wr_size;
  logic [`CNN_DATA_W-1:0] pic_data, wgt_data, wr_data;

  logic [7:0] mem [MEM_BYTES];
  int         seed;
  int         rd_max, wr_max;
  bit         fixed_lat;                  // Always use the longest latency
  bit         timed_out;
  int         small_bias;

  cnn_top dut0 (
    .clk(clk), .rst_n(rst_n), .go(go),
    .addr_bias(addr_bias), .addr_x(addr_x), .addr_y(addr_y), .addr_z(addr_z),
    .x_m(x_m), .x_n(x_n), .busy(busy), .done(done),
    .pic_req(pic_req), .pic_addr(pic_addr), .pic_size(pic_size),
    .pic_valid(pic_valid), .pic_data(pic_data),
    .wgt_req(wgt_req), .wgt_addr(wgt_addr), .wgt_size(wgt_size),
    .wgt_valid(wgt_valid), .wgt_data(wgt_data),
    .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_size(wr_size),
    .wr_ack(wr_ack)
  );

  cnn_checker #(.MEM_BYTES(MEM_BYTES)) chk (
    .clk(clk), .rst_n(rst_n), .go(go), .busy(busy), .done(done),
    .pic_req(pic_req), .pic_valid(pic_valid), .pic_size(pic_size),
    .wgt_req(wgt_req), .wgt_valid(wgt_valid), .wgt_size(wgt_size),
    .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_size(wr_size),
    .wr_ack(wr_ack), .mem(mem)
  );

  function automatic int draw_lat(input int max_lat);
    if (fixed_lat)
      return max_lat;
    return 1 + int'($unsigned($random(seed)) % max_lat);
  endfunction

  function automatic logic [31:0] read_word(input logic [`CNN_ADDR_W-1:0] a);
    int i;
    i = int'(a);
    return {mem[i+3], mem[i+2], mem[i+1], mem[i]};  // Lowest address in the low byte
  endfunction

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==========================================================================
  // Memory model: picture port, kernel port, write port
  // ==========================================================================
  initial
  begin
    int lat;
    pic_valid = 1'b0;
    pic_data  = '0;
    forever
    begin
      @(posedge clk);
      #2;
      if (pic_req)
      begin
        lat = draw_lat(rd_max);
        repeat (lat - 1)
        begin
          @(posedge clk);
          #2;
        end
        pic_data  = read_word(pic_addr);
        pic_valid = 1'b1;
        @(posedge clk);
        #2;
        pic_valid = 1'b0;
      end
    end
  end

  initial
  begin
    int lat;
    wgt_valid = 1'b0;
    wgt_data  = '0;
    forever
    begin
      @(posedge clk);
      #2;
      if (wgt_req)
      begin
        lat = draw_lat(rd_max);
        repeat (lat - 1)
        begin
          @(posedge clk);
          #2;
        end
        wgt_data  = read_word(wgt_addr);
        wgt_valid = 1'b1;
        @(posedge clk);
        #2;
        wgt_valid = 1'b0;
      end
    end
  end

  initial
  begin
    int lat;
    wr_ack = 1'b0;
    forever
    begin
      @(posedge clk);
      #2;
      if (wr_req)
      begin
        lat = draw_lat(wr_max);
        repeat (lat - 1)
        begin
          @(posedge clk);
          #2;
        end
        wr_ack = 1'b1;                    // Results are checked, not stored
        @(posedge clk);
        #2;
        wr_ack = 1'b0;
      end
    end
  end

  task automatic load_picture(input int m, input int n);
    for (int i = 0; i < `CNN_DP_DEPTH * `CNN_DP_DEPTH; i++)
      mem[A_KERN + i] = 8'($random(seed));
    for (int i = 0; i < m * n; i++)
      mem[A_PIC + i] = 8'($random(seed));
  endtask

  task automatic set_bias(input int b);
    for (int k = 0; k < 4; k++)
      mem[A_BIAS + k] = 8'(b >>> (8 * k));  // Little endian
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!done && cycles < WAIT_LIMIT)
    begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!done)
    begin
      timed_out = 1'b1;
      chk.abort_test("timed out waiting for done");
    end
    else
    begin
      @(posedge clk);                     // Checker closes the test at this edge
      #2;
    end
  endtask

  // A go while busy must leave the run untouched
  task automatic go_while_busy();
    int cycles;
    cycles = 0;
    while (!busy && cycles < WAIT_LIMIT)
    begin
      @(posedge clk);
      #2;
      cycles++;
    end
    if (!busy)
    begin
      timed_out = 1'b1;
      chk.abort_test("timed out waiting for busy");
    end
    else
    begin
      repeat (6) @(posedge clk);
      #2;
      addr_z = `CNN_ADDR_W'(A_RES + 'h80);
      addr_x = `CNN_ADDR_W'(A_KERN);
      go     = 1'b1;
      @(posedge clk);
      #2;
      go     = 1'b0;
      addr_z = `CNN_ADDR_W'(A_RES);
      addr_x = `CNN_ADDR_W'(A_PIC);
    end
  endtask

  task automatic run_conv(input int id, input string name, input int m, input int n,
                          input bit poke_busy);
    if (!timed_out)
    begin
      chk.begin_test(id, name, A_BIAS, A_PIC, A_KERN, A_RES, m, n);
      @(posedge clk);
      #2;
      x_m = `CNN_DIM_W'(m);
      x_n = `CNN_DIM_W'(n);
      go  = 1'b1;
      @(posedge clk);
      #2;
      go  = 1'b0;
      if (poke_busy)
        go_while_busy();
      if (!timed_out)
        wait_done();
    end
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial
  begin
    seed      = 32'hf4e2;
    rd_max    = 6;
    wr_max    = 8;
    fixed_lat = 1'b0;
    timed_out = 1'b0;
    rst_n     = 1'b0;
    go        = 1'b0;
    addr_bias = `CNN_ADDR_W'(A_BIAS);
    addr_x    = `CNN_ADDR_W'(A_PIC);
    addr_y    = `CNN_ADDR_W'(A_KERN);
    addr_z    = `CNN_ADDR_W'(A_RES);
    x_m       = `CNN_DIM_W'(8);
    x_n       = `CNN_DIM_W'(8);
    for (int i = 0; i < MEM_BYTES; i++)
      mem[i] = 8'(i ^ (i >> 8));          // Background fill over the whole address
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    chk.idle_check(0, "status after reset");

    load_picture(8, 8);
    small_bias = $random(seed) % 64;
    set_bias(small_bias);
    run_conv(1, "8x8 random kernel", 8, 8, 1'b0);
    fixed_lat = 1'b1;                     // Same data, longest latencies
    run_conv(2, "8x8 slow memory", 8, 8, 1'b0);
    fixed_lat = 1'b0;
    set_bias(1000000);
    run_conv(3, "clip to 255", 8, 8, 1'b0);
    set_bias(-1000000);
    run_conv(4, "clip to 0", 8, 8, 1'b0);
    load_picture(5, 6);
    set_bias(small_bias);
    run_conv(5, "5x6 partial word", 5, 6, 1'b0);
    load_picture(8, 8);
    run_conv(6, "go while busy", 8, 8, 1'b1);

    chk.print_counts();
    if (timed_out || chk.fail_cnt != 0)
      $display("SOME TESTS FAILED");
    else
      $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: tb/cnn_checker.sv
// Result checker: reference convolution, read sizes, write port and status watcher, counts
`timescale 1ns/1ns
`include "cnn_cfg.svh"

module cnn_checker
  import cnn_pkg::*;
#(
  parameter int MEM_BYTES = 1024
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    go,
  input  logic                    busy,
  input  logic                    done,
  input  logic                    pic_req,
  input  logic                    pic_valid,
  input  logic [`CNN_SIZE_W-1:0]  pic_size,
  input  logic                    wgt_req,
  input  logic                    wgt_valid,
  input  logic [`CNN_SIZE_W-1:0]  wgt_size,
  input  logic                    wr_req,
  input  logic [`CNN_ADDR_W-1:0]  wr_addr,
  input  logic [`CNN_DATA_W-1:0]  wr_data,
  input  logic [`CNN_SIZE_W-1:0]  wr_size,
  input  logic                    wr_ack,
  input  logic [7:0]              mem [MEM_BYTES]
);

  int         test_id   = 0;
  string      test_name = "";
  bit         running   = 1'b0;           // From accepted go until done
  bit         done_q    = 1'b0;
  int         n_res     = 0;
  int         n_words   = 0;
  int         word_idx  = 0;
  int         test_errs = 0;
  int         pass_cnt  = 0;
  int         fail_cnt  = 0;
  int         base_z    = 0;
  logic [7:0] exp_b [$];                  // Expected result bytes in write order

  // One output byte of window (r, c) straight from memory contents
  function automatic logic [7:0] window_ref(input int ab, input int ax, input int ay,
                                            input int n, input int r, input int c);
    acc_t acc;
    acc_t bias;
    int   pix;
    int   wgt;
    acc  = '0;
    bias = acc_t'({mem[ab+3], mem[ab+2], mem[ab+1], mem[ab]});
    for (int i = 0; i < `CNN_DP_DEPTH; i++)
      for (int j = 0; j < `CNN_DP_DEPTH; j++)
      begin
        pix = int'(mem[ax + (r + i) * n + c + j]);           // Unsigned pixel
        wgt = int'(wgt_t'(mem[ay + `CNN_DP_DEPTH * i + j])); // Signed weight
        acc = acc + acc_t'(pix * wgt);
      end
    acc = acc + bias;
    if (acc < 0)
      return 8'd0;
    else if (acc > 255)
      return 8'd255;
    else
      return acc[7:0];
  endfunction

  task automatic begin_test(input int id, input string name, input int ab, input int ax,
                            input int ay, input int az, input int m, input int n);
    exp_b.delete();
    for (int r = 0; r <= m - `CNN_DP_DEPTH; r++)
      for (int c = 0; c <= n - `CNN_DP_DEPTH; c++)
        exp_b.push_back(window_ref(ab, ax, ay, n, r, c));
    test_id   = id;
    test_name = name;
    n_res     = exp_b.size();
    n_words   = (n_res + `CNN_WR_BYTES - 1) / `CNN_WR_BYTES;
    word_idx  = 0;
    test_errs = 0;
    base_z    = az;
  endtask

  task automatic error_line(input string msg);
    $display("** Error at %0t ns: test %0d %s", $time, test_id, msg);
    test_errs++;
  endtask

  task automatic stray(input string msg);
    $display("Test %0d: %s at %0t ns", test_id, msg, $time);
    fail_cnt++;
  endtask

  task automatic end_test();
    if (test_errs == 0)
    begin
      pass_cnt++;
      $display("Test %0d %s: passed, %0d words written", test_id, test_name, word_idx);
    end
    else
    begin
      fail_cnt++;
      $display("Test %0d %s: failed with %0d errors", test_id, test_name, test_errs);
    end
  endtask

  task automatic idle_check(input int id, input string name);
    test_id   = id;
    test_name = name;
    test_errs = 0;
    word_idx  = 0;
    if (busy !== 1'b0)
      error_line("busy is not low while idle");
    if (done !== 1'b0)
      error_line("done is not low while idle");
    if (wr_req !== 1'b0)
      error_line("write request is not low while idle");
    end_test();
  endtask

  task automatic abort_test(input string msg);
    $display("Test %0d %s: %s", test_id, test_name, msg);
    fail_cnt++;
    running = 1'b0;
  endtask

  task automatic print_counts();
    $display("Tests run: %0d, passed: %0d, failed: %0d", pass_cnt + fail_cnt, pass_cnt,
             fail_cnt);
  endtask

  task automatic check_write();
    logic [`CNN_DATA_W-1:0] exp_d;
    int                     sz;
    if (!running || word_idx >= n_words)
      stray("write with no result left to write");
    else
    begin
      sz = n_res - `CNN_WR_BYTES * word_idx;
      if (sz > `CNN_WR_BYTES)
        sz = `CNN_WR_BYTES;
      exp_d = '0;                         // Unused bytes must be zero
      for (int k = 0; k < sz; k++)
        exp_d[8*k +: 8] = exp_b[`CNN_WR_BYTES * word_idx + k];
      if (int'(wr_addr) != base_z + `CNN_WR_BYTES * word_idx)
        error_line($sformatf("word %0d address %h, expected %h", word_idx, wr_addr,
                             base_z + `CNN_WR_BYTES * word_idx));
      if (int'(wr_size) != sz)
        error_line($sformatf("word %0d size %0d, expected %0d", word_idx, wr_size, sz));
      if (wr_data !== exp_d)
        error_line($sformatf("word %0d data %h, expected %h", word_idx, wr_data, exp_d));
      word_idx++;
    end
  endtask

  // ==========================================================================
  // Watcher, sampled at the rising edge
  // ==========================================================================
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (pic_req && pic_valid && int'(pic_size) != `CNN_DP_DEPTH)
        error_line($sformatf("picture read size %0d, expected %0d", pic_size,
                             `CNN_DP_DEPTH));
      if (wgt_req && wgt_valid && int'(wgt_size) != `CNN_DP_DEPTH)
        error_line($sformatf("kernel read size %0d, expected %0d", wgt_size,
                             `CNN_DP_DEPTH));
      if (wr_req && wr_ack)
        check_write();
      if (done && done_q)
        stray("done stayed high for more than one cycle");
      if (running)
      begin
        if (done)
        begin
          if (busy)
            error_line("busy still high while done pulses");
          if (word_idx != n_words)
            error_line($sformatf("%0d words written, expected %0d", word_idx, n_words));
          end_test();
          running = 1'b0;
        end
        else if (!busy)
          error_line("busy low before done");
      end
      else if (done && !done_q)
        stray("done pulsed with no run active");
      if (go && !busy && !running)
        running = 1'b1;                   // Accepted go starts a run
    end
    done_q = done;
  end

endmodule

// File: verilog/cnn_top.sv
// Convolution engine top level: controller, pixel and kernel read channels, MAC, write packer
`timescale 1ns/1ns
`include "cnn_cfg.svh"

module cnn_top
  import cnn_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  // Software side
  input  logic                    go,
  input  logic [`CNN_ADDR_W-1:0]  addr_bias,
  input  logic [`CNN_ADDR_W-1:0]  addr_x,
  input  logic [`CNN_ADDR_W-1:0]  addr_y,
  input  logic [`CNN_ADDR_W-1:0]  addr_z,
  input  logic [`CNN_DIM_W-1:0]   x_m,
  input  logic [`CNN_DIM_W-1:0]   x_n,
  output logic                    busy,
  output logic                    done,
  // Picture read port
  output logic                    pic_req,
  output logic [`CNN_ADDR_W-1:0]  pic_addr,
  output logic [`CNN_SIZE_W-1:0]  pic_size,
  input  logic                    pic_valid,
  input  logic [`CNN_DATA_W-1:0]  pic_data,
  // Kernel and bias read port
  output logic                    wgt_req,
  output logic [`CNN_ADDR_W-1:0]  wgt_addr,
  output logic [`CNN_SIZE_W-1:0]  wgt_size,
  input  logic                    wgt_valid,
  input  logic [`CNN_DATA_W-1:0]  wgt_data,
  // Result write port
  output logic                    wr_req,
  output logic [`CNN_ADDR_W-1:0]  wr_addr,
  output logic [`CNN_DATA_W-1:0]  wr_data,
  output logic [`CNN_SIZE_W-1:0]  wr_size,
  input  logic                    wr_ack
);

  logic                   pic_start, wgt_start;
  logic [`CNN_ADDR_W-1:0] pic_rd_addr, wgt_rd_addr;
  logic                   pic_vld, wgt_vld;
  pix_row_t               pic_row;
  wgt_row_t               wgt_row;
  logic                   bias_sel;
  krow_t                  krow;
  logic                   win_last;
  pix_t                   res_byte;
  logic                   res_vld;
  logic                   wr_busy, flush, flushed;

  cnn_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .go         (go),
    .addr_bias  (addr_bias),
    .addr_x     (addr_x),
    .addr_y     (addr_y),
    .x_m        (x_m),
    .x_n        (x_n),
    .pic_start  (pic_start),
    .pic_addr_o (pic_rd_addr),
    .wgt_start  (wgt_start),
    .wgt_addr_o (wgt_rd_addr),
    .pic_vld    (pic_vld),
    .wgt_vld    (wgt_vld),
    .bias_sel   (bias_sel),
    .krow       (krow),
    .win_last   (win_last),
    .wr_busy    (wr_busy),
    .flush      (flush),
    .flushed    (flushed),
    .busy       (busy),
    .done       (done)
  );

  cnn_rd_chan #(.elem_t(pix_t)) u_pic_chan (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (pic_start),
    .addr     (pic_rd_addr),
    .req      (pic_req),
    .mem_addr (pic_addr),
    .size     (pic_size),
    .valid    (pic_valid),
    .mem_data (pic_data),
    .data     (pic_row),
    .vld      (pic_vld)
  );

  cnn_rd_chan #(.elem_t(wgt_t)) u_wgt_chan (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (wgt_start),
    .addr     (wgt_rd_addr),
    .req      (wgt_req),
    .mem_addr (wgt_addr),
    .size     (wgt_size),
    .valid    (wgt_valid),
    .mem_data (wgt_data),
    .data     (wgt_row),
    .vld      (wgt_vld)
  );

  cnn_mac u_mac (
    .clk      (clk),
    .rst_n    (rst_n),
    .wgt_row  (wgt_row),
    .wgt_vld  (wgt_vld),
    .bias_sel (bias_sel),
    .krow     (krow),
    .pic_row  (pic_row),
    .pic_vld  (pic_vld),
    .win_last (win_last),
    .res_byte (res_byte),
    .res_vld  (res_vld)
  );

  cnn_wr_pack u_wr_pack (
    .clk      (clk),
    .rst_n    (rst_n),
    .go       (go),
    .addr_z   (addr_z),
    .res_byte (res_byte),
    .res_vld  (res_vld),
    .flush    (flush),
    .wr_busy  (wr_busy),
    .flushed  (flushed),
    .wr_req   (wr_req),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_size  (wr_size),
    .wr_ack   (wr_ack)
  );

endmodule

// File: verilog/cnn_wr_pack.sv
// Result write packer: byte packing into words, write requests, final partial flush
`timescale 1ns/1ns
`include "cnn_cfg.svh"

module cnn_wr_pack
  import cnn_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    go,
  input  logic [`CNN_ADDR_W-1:0]  addr_z,
  input  pix_t                    res_byte,
  input  logic                    res_vld,
  input  logic                    flush,
  output logic                    wr_busy,
  output logic                    flushed,
  output logic                    wr_req,
  output logic [`CNN_ADDR_W-1:0]  wr_addr,
  output logic [`CNN_DATA_W-1:0]  wr_data,
  output logic [`CNN_SIZE_W-1:0]  wr_size,
  input  logic                    wr_ack
);

  localparam logic [`CNN_SIZE_W-1:0] FULL = `CNN_SIZE_W'(`CNN_WR_BYTES);

  logic                   active;         // From go until flushed
  logic                   fin;            // Pending word is the flushed one
  logic [`CNN_SIZE_W-1:0] cnt;            // Bytes in the word
  logic [`CNN_DATA_W-1:0] word;
  logic                   start, cap_full;

  assign start    = go && !active;
  assign cap_full = res_vld && (cnt == FULL - 1'b1);
  assign wr_busy  = wr_req || cap_full;
  assign wr_data  = word;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active  <= 1'b0;
      fin     <= 1'b0;
      cnt     <= '0;
      wr_req  <= 1'b0;
      flushed <= 1'b0;
    end
    else
    begin
      flushed <= 1'b0;
      if (start)
      begin
        active <= 1'b1;
        fin    <= 1'b0;
        cnt    <= '0;
      end
      else if (wr_ack)
      begin
        wr_req <= 1'b0;
        cnt    <= '0;
        if (fin)
        begin
          fin     <= 1'b0;
          flushed <= 1'b1;
          active  <= 1'b0;
        end
      end
      else
      begin
        if (res_vld)
          cnt <= cnt + 1'b1;
        if (cap_full)
          wr_req <= 1'b1;
        if (flush)
        begin
          if (cnt == '0)
          begin
            flushed <= 1'b1;              // Nothing left to write
            active  <= 1'b0;
          end
          else
          begin
            wr_req <= 1'b1;
            fin    <= 1'b1;
          end
        end
      end
    end
  end

  // ==========================================================================
  // Word, address and size
  // ==========================================================================
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      word    <= '0;
      wr_addr <= addr_z;
    end
    else if (wr_ack)
    begin
      word    <= '0;                      // Unused bytes of a partial word stay zero
      wr_addr <= wr_addr + `CNN_ADDR_W'(`CNN_WR_BYTES);
    end
    else
    begin
      if (res_vld)
        word[8*int'(cnt) +: 8] <= res_byte;  // First result in the low byte
      if (cap_full)
        wr_size <= FULL;
      if (flush)
        wr_size <= cnt;
    end
  end

endmodule

// File: verilog/cnn_mac.sv
// Convolution MAC: kernel and bias storage, 4-lane dot product, accumulation, bias and clipping
`timescale 1ns/1ns
`include "cnn_cfg.svh"

module cnn_mac
  import cnn_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  wgt_row_t  wgt_row,
  input  logic      wgt_vld,
  input  logic      bias_sel,
  input  krow_t     krow,
  input  pix_row_t  pic_row,
  input  logic      pic_vld,
  input  logic      win_last,
  output pix_t      res_byte,
  output logic      res_vld
);

  wgt_row_t kern [`CNN_DP_DEPTH];
  acc_t     bias_q;
  acc_t     acc_q;
  acc_t     dp, acc_nxt, sum;
  pix_t     clip;

  // ==========================================================================
  // Dot product and activation
  // ==========================================================================
  always_comb
  begin
    dp = '0;
    for (int i = 0; i < `CNN_DP_DEPTH; i++)
      dp = dp + acc_t'($signed({1'b0, pic_row[i]})) * acc_t'($signed(kern[krow][i]));
    acc_nxt = ((krow == '0) ? acc_t'(0) : acc_q) + dp;  // Row 0 restarts the window
    sum     = acc_nxt + bias_q;
    if (sum < 0)
      clip = 8'd0;
    else if (sum > 255)
      clip = 8'd255;
    else
      clip = sum[7:0];
  end

  always_ff @(posedge clk)
  begin
    if (wgt_vld)
    begin
      if (bias_sel)
        bias_q <= acc_t'(wgt_row);        // Little endian word
      else
        kern[krow] <= wgt_row;
    end
    if (pic_vld)
      acc_q <= acc_nxt;
    if (pic_vld && win_last)
      res_byte <= clip;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      res_vld <= 1'b0;
    else
      res_vld <= pic_vld && win_last;     // One cycle after the last row
  end

endmodule

// File: verilog/cnn_rd_chan.sv
// Memory read channel: request handshake and row register, element type set by parameter
`timescale 1ns/1ns
`include "cnn_cfg.svh"

module cnn_rd_chan
  import cnn_pkg::*;
#(
  parameter type elem_t = pix_t
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic [`CNN_ADDR_W-1:0]       addr,
  output logic                         req,
  output logic [`CNN_ADDR_W-1:0]       mem_addr,
  output logic [`CNN_SIZE_W-1:0]       size,
  input  logic                         valid,
  input  logic [`CNN_DATA_W-1:0]       mem_data,
  output elem_t [`CNN_DP_DEPTH-1:0]    data,
  output logic                         vld
);

  localparam int EW = $bits(elem_t);

  assign size = `CNN_SIZE_W'(`CNN_DP_DEPTH);   // Always a full row

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req <= 1'b0;
      vld <= 1'b0;
    end
    else
    begin
      vld <= valid;
      if (start)
        req <= 1'b1;
      else if (valid)
        req <= 1'b0;                      // Low in the cycle after valid
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
      mem_addr <= addr;
    if (valid)
      for (int i = 0; i < `CNN_DP_DEPTH; i++)
        data[i] <= elem_t'(mem_data[i*EW +: EW]);  // Lowest address to element 0
  end

endmodule

// File: verilog/cnn_ctrl.sv
// Convolution engine controller: sequencing FSM, window and row indexes, read addresses, busy, done
`timescale 1ns/1ns
`include "cnn_cfg.svh"

module cnn_ctrl
  import cnn_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    go,
  input  logic [`CNN_ADDR_W-1:0]  addr_bias,
  input  logic [`CNN_ADDR_W-1:0]  addr_x,
  input  logic [`CNN_ADDR_W-1:0]  addr_y,
  input  logic [`CNN_DIM_W-1:0]   x_m,
  input  logic [`CNN_DIM_W-1:0]   x_n,
  output logic                    pic_start,
  output logic [`CNN_ADDR_W-1:0]  pic_addr_o,
  output logic                    wgt_start,
  output logic [`CNN_ADDR_W-1:0]  wgt_addr_o,
  input  logic                    pic_vld,
  input  logic                    wgt_vld,
  output logic                    bias_sel,
  output krow_t                   krow,
  output logic                    win_last,
  input  logic                    wr_busy,
  output logic                    flush,
  input  logic                    flushed,
  output logic                    busy,
  output logic                    done
);

  localparam krow_t                  KLAST = krow_t'(`CNN_DP_DEPTH - 1);
  localparam logic [`CNN_DIM_W-1:0]  KDIM  = `CNN_DIM_W'(`CNN_DP_DEPTH);

  typedef enum logic [2:0] {IDLE, BIAS, KERNEL, WAIT_WR, ROWS, FLUSH, FINISH} state_t;

  state_t                 st;
  logic [`CNN_ADDR_W-1:0] ax_q, ay_q;     // Picture and kernel base addresses
  logic [`CNN_DIM_W-1:0]  xm_q, xn_q;
  logic [`CNN_DIM_W-1:0]  win_r, win_c;   // Top left corner of current window
  krow_t                  k_nxt;
  logic                   last_col, last_row;

  assign k_nxt    = krow + krow_t'(1);
  assign last_col = (win_c == xn_q - KDIM);
  assign last_row = (win_r == xm_q - KDIM);
  assign win_last = (st == ROWS) && (krow == KLAST);

  // Picture row k of the current window
  function automatic logic [`CNN_ADDR_W-1:0] pic_row_addr(input krow_t k);
    logic [`CNN_ADDR_W-1:0] row;
    row = `CNN_ADDR_W'(win_r) + `CNN_ADDR_W'(k);
    return ax_q + row * `CNN_ADDR_W'(xn_q) + `CNN_ADDR_W'(win_c);
  endfunction

  always_ff @(posedge clk)
  begin
    if (go && !busy)
    begin
      ax_q <= addr_x;
      ay_q <= addr_y;
      xm_q <= x_m;
      xn_q <= x_n;
    end
  end

  // ==========================================================================
  // Sequencing FSM
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      st         <= IDLE;
      krow       <= '0;
      win_r      <= '0;
      win_c      <= '0;
      pic_start  <= 1'b0;
      wgt_start  <= 1'b0;
      pic_addr_o <= '0;
      wgt_addr_o <= '0;
      bias_sel   <= 1'b0;
      flush      <= 1'b0;
      busy       <= 1'b0;
      done       <= 1'b0;
    end
    else
    begin
      pic_start <= 1'b0;                  // Start, flush and done are single pulses
      wgt_start <= 1'b0;
      flush     <= 1'b0;
      done      <= 1'b0;
      case (st)
        IDLE:
          if (go && !busy)
          begin
            busy       <= 1'b1;
            bias_sel   <= 1'b1;
            wgt_start  <= 1'b1;
            wgt_addr_o <= addr_bias;      // Bias comes first over the kernel port
            krow       <= '0;
            win_r      <= '0;
            win_c      <= '0;
            st         <= BIAS;
          end
        BIAS:
          if (wgt_vld)
          begin
            bias_sel   <= 1'b0;
            wgt_start  <= 1'b1;
            wgt_addr_o <= ay_q;
            st         <= KERNEL;
          end
        KERNEL:
          if (wgt_vld)
          begin
            if (krow == KLAST)
            begin
              krow <= '0;
              st   <= WAIT_WR;
            end
            else
            begin
              krow       <= k_nxt;
              wgt_start  <= 1'b1;
              wgt_addr_o <= ay_q + `CNN_ADDR_W'(k_nxt) * `CNN_ADDR_W'(`CNN_DP_DEPTH);
            end
          end
        WAIT_WR:
          if (!wr_busy)                   // Hold off a new window while a word is pending
          begin
            pic_start  <= 1'b1;
            pic_addr_o <= pic_row_addr('0);
            st         <= ROWS;
          end
        ROWS:
          if (pic_vld)
          begin
            if (krow == KLAST)
            begin
              krow <= '0;
              if (last_col && last_row)
                st <= FLUSH;
              else if (last_col)
              begin
                win_c <= '0;
                win_r <= win_r + 1'b1;
                st    <= WAIT_WR;
              end
              else
              begin
                win_c <= win_c + 1'b1;
                st    <= WAIT_WR;
              end
            end
            else
            begin
              krow       <= k_nxt;
              pic_start  <= 1'b1;
              pic_addr_o <= pic_row_addr(k_nxt);
            end
          end
        FLUSH:
          if (!wr_busy)                   // Last byte is captured by now
          begin
            flush <= 1'b1;
            st    <= FINISH;
          end
        FINISH:
          if (flushed)
          begin
            done <= 1'b1;
            busy <= 1'b0;
            st   <= IDLE;
          end
        default:
          st <= IDLE;
      endcase
    end
  end

endmodule

// File: verilog/cnn_pkg.sv
// Convolution engine package: pixel, weight, row, row index and accumulator types
package cnn_pkg;

`include "cnn_cfg.svh"

  typedef logic        [7:0] pix_t;   // Unsigned picture byte
  typedef logic signed [7:0] wgt_t;   // Signed kernel byte

  // Element 0 sits at the lowest byte address
  typedef pix_t [`CNN_DP_DEPTH-1:0] pix_row_t;
  typedef wgt_t [`CNN_DP_DEPTH-1:0] wgt_row_t;

  typedef logic [$clog2(`CNN_DP_DEPTH)-1:0] krow_t;  // Kernel or picture row in a window

  typedef logic signed [31:0] acc_t;  // Accumulator and bias

endpackage

// File: verilog/cnn_cfg.svh
// Convolution engine sizes: address, data bus, size field, kernel and picture limits
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// ==========================================================================
// Memory buses
// ==========================================================================
`define CNN_ADDR_W    19              // Byte address width
`define CNN_DATA_W    32              // Read and write data bus width
`define CNN_SIZE_W    3               // Size field, byte count 0 to 4

// ==========================================================================
// Kernel and picture
// ==========================================================================
`define CNN_DP_DEPTH  4               // Dot product lanes, kernel rows and columns
`define CNN_WR_BYTES  4               // Result bytes per write word
`define CNN_DIM_W     5               // Picture rows and columns up to 16

`endif
